//--- hdu_pkg.sv
package hdu_pkg;

    // scoreboard geometry
    localparam int SB_DEPTH   = 8;
    localparam int SB_ID_W    = $clog2(SB_DEPTH);
    localparam int REG_ADDR_W = 5;

    // at most this many valid entries still leaves room for a pair
    localparam int SB_MAX_USED_FOR_TWO = SB_DEPTH - 2;

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [SB_ID_W-1:0]    sb_id_t;
    typedef logic [SB_DEPTH-1:0]   sb_mask_t;

    localparam reg_addr_t REG_ZERO = '0;  // x0, never a hazard

    // unit that will write the destination
    typedef enum logic [1:0] {
        EXU_ALU = 2'd0,
        EXU_MUL = 2'd1,
        EXU_DIV = 2'd2,
        EXU_CSR = 2'd3
    } exu_type_e;

    // bit 0 issues inst1, bit 1 issues inst2
    typedef logic [1:0] issue_t;

    localparam issue_t ISSUE_NONE  = 2'b00;
    localparam issue_t ISSUE_FIRST = 2'b01;
    localparam issue_t ISSUE_BOTH  = 2'b11;

endpackage

//--- hdu_if.sv
`timescale 1ns/100ps

// one decoded instruction as seen by the hazard unit
interface inst_if import hdu_pkg::*; ();
    logic      valid;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    logic      rd_we;
    exu_type_e exu;

    modport src (output valid, rd, rs1, rs2, rd_we, exu);
    modport dst (input  valid, rd, rs1, rs2, rd_we, exu);
endinterface

// current scoreboard contents
interface sb_view_if import hdu_pkg::*; ();
    sb_mask_t  entry_valid;
    sb_mask_t  entry_live;            // valid and not completing this cycle
    reg_addr_t entry_rd  [SB_DEPTH];
    exu_type_e entry_exu [SB_DEPTH];

    modport owner  (output entry_valid, entry_live, entry_rd, entry_exu);
    modport reader (input  entry_valid, entry_live, entry_rd, entry_exu);
endinterface

// slot allocation and scoreboard write enables
interface alloc_if import hdu_pkg::*; ();
    sb_id_t id1;
    sb_id_t id2;
    logic   can_two;  // at least two slots free
    logic   we1;
    logic   we2;

    modport picker   (output id1, id2, can_two);
    modport ctrl     (input  can_two, output we1, we2);
    modport sb_table (input  id1, id2, can_two, we1, we2);
endinterface

//--- scoreboard.sv
`timescale 1ns/100ps

module scoreboard import hdu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      commit_valid_i,
    input  sb_id_t    commit_id_i,
    input  logic      commit2_valid_i,
    input  sb_id_t    commit2_id_i,
    inst_if.dst       inst1,
    inst_if.dst       inst2,
    alloc_if.sb_table alloc,
    sb_view_if.owner  view,
    output logic      busy_o
);

    sb_mask_t  sb_valid;
    sb_mask_t  live;
    sb_mask_t  valid_nxt;
    reg_addr_t sb_rd  [SB_DEPTH];
    exu_type_e sb_exu [SB_DEPTH];

    // completions hide their entry already in this cycle
    always_comb begin
        live = sb_valid;
        if (commit_valid_i)
            live[commit_id_i] = 1'b0;
        if (commit2_valid_i)
            live[commit2_id_i] = 1'b0;
    end

    // allocated slots are free, so set never collides with clear
    always_comb begin
        valid_nxt = live;
        if (alloc.we1)
            valid_nxt[alloc.id1] = 1'b1;
        if (alloc.we2)
            valid_nxt[alloc.id2] = 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sb_valid <= '0;
        end else begin
            sb_valid <= valid_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc.we1) begin
            sb_rd[alloc.id1]  <= inst1.rd;
            sb_exu[alloc.id1] <= inst1.exu;
        end
        if (alloc.we2) begin
            sb_rd[alloc.id2]  <= inst2.rd;
            sb_exu[alloc.id2] <= inst2.exu;
        end
    end

    assign view.entry_valid = sb_valid;
    assign view.entry_live  = live;
    assign view.entry_rd    = sb_rd;
    assign view.entry_exu   = sb_exu;

    assign busy_o = |sb_valid;  // long writes still outstanding

endmodule

//--- slot_alloc.sv
`timescale 1ns/100ps

module slot_alloc import hdu_pkg::*; (
    sb_view_if.reader view,
    alloc_if.picker   alloc
);

    logic [SB_ID_W:0] used_cnt;  // 0..SB_DEPTH
    logic             found1;
    logic             found2;
    sb_id_t           id1;
    sb_id_t           id2;
    sb_id_t           cand;

    always_comb begin
        used_cnt = '0;
        for (int i = 0; i < SB_DEPTH; i++)
            used_cnt = used_cnt + view.entry_valid[i];
    end

    // lowest free slot
    always_comb begin
        found1 = 1'b0;
        id1    = '0;
        for (int i = 0; i < SB_DEPTH; i++) begin
            if (!found1 && !view.entry_valid[i]) begin
                found1 = 1'b1;
                id1    = sb_id_t'(i);
            end
        end
    end

    // next free slot above id1, index wraps at SB_DEPTH
    always_comb begin
        found2 = 1'b0;
        id2    = '0;
        cand   = '0;
        for (int k = 1; k < SB_DEPTH; k++) begin
            cand = sb_id_t'(id1 + k);
            if (found1 && !found2 && !view.entry_valid[cand]) begin
                found2 = 1'b1;
                id2    = cand;
            end
        end
    end

    assign alloc.id1     = id1;
    assign alloc.id2     = id2;
    assign alloc.can_two = (used_cnt <= (SB_ID_W + 1)'(SB_MAX_USED_FOR_TWO));

endmodule

//--- hazard_check.sv
`timescale 1ns/100ps

module hazard_check import hdu_pkg::*; (
    inst_if.dst       inst1,
    inst_if.dst       inst2,
    sb_view_if.reader view,
    output logic      haz1_sb_o,
    output logic      haz2_sb_o,
    output logic      haz_pair_o,
    output logic      dst1_live_o,
    output logic      dst2_live_o
);

    logic     use1_rs1;
    logic     use1_rs2;
    logic     use2_rs1;
    logic     use2_rs2;
    logic     dst1;
    logic     dst2;
    sb_mask_t hit1;  // per-entry conflicts of inst1
    sb_mask_t hit2;
    logic     raw_pair;
    logic     waw_pair;

    // x0 sources and destinations never count
    assign use1_rs1 = inst1.valid && (inst1.rs1 != REG_ZERO);
    assign use1_rs2 = inst1.valid && (inst1.rs2 != REG_ZERO);
    assign use2_rs1 = inst2.valid && (inst2.rs1 != REG_ZERO);
    assign use2_rs2 = inst2.valid && (inst2.rs2 != REG_ZERO);

    assign dst1 = inst1.valid && inst1.rd_we && (inst1.rd != REG_ZERO);
    assign dst2 = inst2.valid && inst2.rd_we && (inst2.rd != REG_ZERO);

    // RAW on either source, WAW only against a different unit
    for (genvar i = 0; i < SB_DEPTH; i++) begin : g_entry
        assign hit1[i] = view.entry_live[i] && (
            (use1_rs1 && (inst1.rs1 == view.entry_rd[i])) ||
            (use1_rs2 && (inst1.rs2 == view.entry_rd[i])) ||
            (dst1 && (inst1.rd == view.entry_rd[i]) &&
                (inst1.exu != view.entry_exu[i])));

        assign hit2[i] = view.entry_live[i] && (
            (use2_rs1 && (inst2.rs1 == view.entry_rd[i])) ||
            (use2_rs2 && (inst2.rs2 == view.entry_rd[i])) ||
            (dst2 && (inst2.rd == view.entry_rd[i]) &&
                (inst2.exu != view.entry_exu[i])));
    end

    // inst2 reads what inst1 writes
    assign raw_pair = dst1 && (
        (use2_rs1 && (inst2.rs1 == inst1.rd)) ||
        (use2_rs2 && (inst2.rs2 == inst1.rd)));

    assign waw_pair = dst1 && dst2 && (inst1.rd == inst2.rd);

    assign haz1_sb_o   = |hit1;
    assign haz2_sb_o   = |hit2;
    assign haz_pair_o  = raw_pair || waw_pair;
    assign dst1_live_o = dst1;
    assign dst2_live_o = dst2;

endmodule

//--- issue_ctrl.sv
`timescale 1ns/100ps

module issue_ctrl import hdu_pkg::*; (
    input  logic   haz1_sb_i,
    input  logic   haz2_sb_i,
    input  logic   haz_pair_i,
    input  logic   dst1_live_i,
    input  logic   dst2_live_i,
    input  logic   jump_i,
    input  logic   branch_i,
    input  logic   irq_i,
    alloc_if.ctrl  alloc,
    output issue_t issue_o
);

    issue_t issue;

    // first matching rule wins
    always_comb begin
        if (!alloc.can_two) begin
            issue = ISSUE_NONE;   // no room for a pair
        end else if (irq_i) begin
            issue = ISSUE_NONE;
        end else if (haz1_sb_i) begin
            issue = ISSUE_NONE;   // inst1 blocked, hold both
        end else if (jump_i || branch_i) begin
            issue = ISSUE_FIRST;  // control flow goes alone
        end else if (haz2_sb_i || haz_pair_i) begin
            issue = ISSUE_FIRST;
        end else begin
            issue = ISSUE_BOTH;
        end
    end

    assign issue_o = issue;

    // only issued writers take a slot
    assign alloc.we1 = dst1_live_i && issue[0];
    assign alloc.we2 = dst2_live_i && issue[1];

endmodule

//--- hdu_top.sv
`timescale 1ns/100ps

module hdu_top import hdu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    input  logic      inst1_valid_i,
    input  reg_addr_t inst1_rd_i,
    input  reg_addr_t inst1_rs1_i,
    input  reg_addr_t inst1_rs2_i,
    input  logic      inst1_rd_we_i,
    input  exu_type_e inst1_exu_i,

    input  logic      inst2_valid_i,
    input  reg_addr_t inst2_rd_i,
    input  reg_addr_t inst2_rs1_i,
    input  reg_addr_t inst2_rs2_i,
    input  logic      inst2_rd_we_i,
    input  exu_type_e inst2_exu_i,

    input  logic      commit_valid_i,
    input  sb_id_t    commit_id_i,
    input  logic      commit2_valid_i,
    input  sb_id_t    commit2_id_i,

    input  logic      jump_i,    // inst1 is a jump
    input  logic      branch_i,  // inst1 is a branch
    input  logic      irq_i,

    output issue_t    issue_o,
    output sb_id_t    inst1_id_o,
    output sb_id_t    inst2_id_o,
    output logic      busy_o
);

    inst_if    inst1_if ();
    inst_if    inst2_if ();
    sb_view_if view_if  ();
    alloc_if   alloc_bus ();

    logic haz1_sb;
    logic haz2_sb;
    logic haz_pair;
    logic dst1_live;
    logic dst2_live;

    assign inst1_if.valid = inst1_valid_i;
    assign inst1_if.rd    = inst1_rd_i;
    assign inst1_if.rs1   = inst1_rs1_i;
    assign inst1_if.rs2   = inst1_rs2_i;
    assign inst1_if.rd_we = inst1_rd_we_i;
    assign inst1_if.exu   = inst1_exu_i;

    assign inst2_if.valid = inst2_valid_i;
    assign inst2_if.rd    = inst2_rd_i;
    assign inst2_if.rs1   = inst2_rs1_i;
    assign inst2_if.rs2   = inst2_rs2_i;
    assign inst2_if.rd_we = inst2_rd_we_i;
    assign inst2_if.exu   = inst2_exu_i;

    scoreboard u_scoreboard (
        .clk             (clk),
        .rst_n           (rst_n),
        .commit_valid_i  (commit_valid_i),
        .commit_id_i     (commit_id_i),
        .commit2_valid_i (commit2_valid_i),
        .commit2_id_i    (commit2_id_i),
        .inst1           (inst1_if),
        .inst2           (inst2_if),
        .alloc           (alloc_bus),
        .view            (view_if),
        .busy_o          (busy_o)
    );

    slot_alloc u_slot_alloc (
        .view  (view_if),
        .alloc (alloc_bus)
    );

    hazard_check u_hazard_check (
        .inst1       (inst1_if),
        .inst2       (inst2_if),
        .view        (view_if),
        .haz1_sb_o   (haz1_sb),
        .haz2_sb_o   (haz2_sb),
        .haz_pair_o  (haz_pair),
        .dst1_live_o (dst1_live),
        .dst2_live_o (dst2_live)
    );

    issue_ctrl u_issue_ctrl (
        .haz1_sb_i   (haz1_sb),
        .haz2_sb_i   (haz2_sb),
        .haz_pair_i  (haz_pair),
        .dst1_live_i (dst1_live),
        .dst2_live_i (dst2_live),
        .jump_i      (jump_i),
        .branch_i    (branch_i),
        .irq_i       (irq_i),
        .alloc       (alloc_bus),
        .issue_o     (issue_o)
    );

    // commit IDs handed to the issue stage
    assign inst1_id_o = alloc_bus.id1;
    assign inst2_id_o = alloc_bus.id2;

endmodule

//--- tb_hdu.sv
`timescale 1ns/100ps

module tb_hdu import hdu_pkg::*; ();

    logic      clk;
    logic      rst_n;
    logic      inst1_valid_i, inst1_rd_we_i, inst2_valid_i, inst2_rd_we_i;
    reg_addr_t inst1_rd_i, inst1_rs1_i, inst1_rs2_i;
    reg_addr_t inst2_rd_i, inst2_rs1_i, inst2_rs2_i;
    exu_type_e inst1_exu_i, inst2_exu_i;
    logic      commit_valid_i, commit2_valid_i;
    sb_id_t    commit_id_i, commit2_id_i;
    logic      jump_i, branch_i, irq_i;
    issue_t    issue_o;
    sb_id_t    inst1_id_o, inst2_id_o;
    logic      busy_o;

    // reference scoreboard
    sb_mask_t  m_valid;
    reg_addr_t m_rd  [SB_DEPTH];
    exu_type_e m_exu [SB_DEPTH];

    integer    seed;
    integer    errors;
    integer    waited;
    issue_t    last_issue;
    sb_id_t    last_id1;

    hdu_top UUT (.*);

    always #2 clk = ~clk;

    function automatic int count_valid();
        int n;
        n = 0;
        for (int i = 0; i < SB_DEPTH; i++)
            n += m_valid[i];
        return n;
    endfunction

    // conflict of one instruction against pending writes
    function automatic logic sb_hazard(input logic v, input reg_addr_t rd, input reg_addr_t rs1,
                                       input reg_addr_t rs2, input logic we, input exu_type_e exu,
                                       input sb_mask_t live);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < SB_DEPTH; i++) begin
            if (live[i] && v) begin
                if (rs1 != 0 && rs1 == m_rd[i])
                    hit = 1'b1;                          // raw on rs1
                if (rs2 != 0 && rs2 == m_rd[i])
                    hit = 1'b1;
                if (we && rd != 0 && rd == m_rd[i] && exu != m_exu[i])
                    hit = 1'b1;                          // waw with another unit
            end
        end
        return hit;
    endfunction

    task automatic clear_inputs();
        inst1_valid_i   = 0;
        inst1_rd_i      = 0;
        inst1_rs1_i     = 0;
        inst1_rs2_i     = 0;
        inst1_rd_we_i   = 0;
        inst1_exu_i     = EXU_ALU;
        inst2_valid_i   = 0;
        inst2_rd_i      = 0;
        inst2_rs1_i     = 0;
        inst2_rs2_i     = 0;
        inst2_rd_we_i   = 0;
        inst2_exu_i     = EXU_ALU;
        commit_valid_i  = 0;
        commit_id_i     = 0;
        commit2_valid_i = 0;
        commit2_id_i    = 0;
        jump_i          = 0;
        branch_i        = 0;
        irq_i           = 0;
    endtask

    task automatic drive_random();
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        r1 = $random(seed);
        r2 = $random(seed);
        r3 = $random(seed);
        inst1_valid_i = r1[0] | r1[1];
        inst1_rd_i    = {2'b00, r1[4:2]};                // x0..x7 only
        inst1_rs1_i   = {2'b00, r1[7:5]};
        inst1_rs2_i   = {2'b00, r1[10:8]};
        inst1_rd_we_i = r1[11] | r1[12];
        inst1_exu_i   = r1[13] ? EXU_ALU : exu_type_e'(r1[15:14]);
        inst2_valid_i = r2[0] | r2[1];
        inst2_rd_i    = {2'b00, r2[4:2]};
        inst2_rs1_i   = {2'b00, r2[7:5]};
        inst2_rs2_i   = {2'b00, r2[10:8]};
        inst2_rd_we_i = r2[11] | r2[12];
        inst2_exu_i   = r2[13] ? EXU_ALU : exu_type_e'(r2[15:14]);
        jump_i        = (r3[2:0] == 0);
        branch_i      = (r3[5:3] == 0);
        irq_i         = (r3[9:6] == 0);
        commit_id_i     = r3[12:10];
        commit_valid_i  = m_valid[r3[12:10]] && r3[13];  // only held entries
        commit2_id_i    = r3[16:14];
        commit2_valid_i = m_valid[r3[16:14]] && r3[17] && (r3[16:14] != r3[12:10]);
    endtask

    // check one cycle and advance the model at the rising edge
    task automatic run_cycle(input string name);
        sb_mask_t live;
        logic     d1, d2, h1, h2, pair, two;
        issue_t   exp_issue, act_issue;
        sb_id_t   exp_id1, exp_id2, act_id1, act_id2;
        logic     found;
        #1;
        live = m_valid;
        if (commit_valid_i)
            live[commit_id_i] = 1'b0;
        if (commit2_valid_i)
            live[commit2_id_i] = 1'b0;
        d1 = inst1_valid_i && inst1_rd_we_i && inst1_rd_i != 0;
        d2 = inst2_valid_i && inst2_rd_we_i && inst2_rd_i != 0;
        h1 = sb_hazard(inst1_valid_i, inst1_rd_i, inst1_rs1_i, inst1_rs2_i,
                       inst1_rd_we_i, inst1_exu_i, live);
        h2 = sb_hazard(inst2_valid_i, inst2_rd_i, inst2_rs1_i, inst2_rs2_i,
                       inst2_rd_we_i, inst2_exu_i, live);
        pair = d1 && inst2_valid_i && ((inst2_rs1_i != 0 && inst2_rs1_i == inst1_rd_i) ||
                                       (inst2_rs2_i != 0 && inst2_rs2_i == inst1_rd_i));
        if (d1 && d2 && inst1_rd_i == inst2_rd_i)
            pair = 1'b1;
        two = (count_valid() <= SB_DEPTH - 2);           // counted before clearing
        if (!two || irq_i || h1)
            exp_issue = 2'b00;
        else if (jump_i || branch_i || h2 || pair)
            exp_issue = 2'b01;
        else
            exp_issue = 2'b11;
        found   = 1'b0;
        exp_id1 = 0;
        for (int i = 0; i < SB_DEPTH; i++) begin
            if (!found && !m_valid[i]) begin
                found   = 1'b1;
                exp_id1 = i;
            end
        end
        found   = 1'b0;
        exp_id2 = 0;
        for (int k = 1; k < SB_DEPTH; k++) begin
            if (!found && !m_valid[(exp_id1 + k) % SB_DEPTH]) begin
                found   = 1'b1;
                exp_id2 = (exp_id1 + k) % SB_DEPTH;
            end
        end
        act_issue = issue_o;
        act_id1   = inst1_id_o;
        act_id2   = inst2_id_o;
        assert (act_issue === exp_issue) else begin
            errors++;
            $display("error %s issue_o expected %b actual %b", name, exp_issue, act_issue);
        end
        assert (busy_o === (m_valid != 0)) else begin
            errors++;
            $display("error %s busy_o expected %b actual %b", name, m_valid != 0, busy_o);
        end
        if (two) begin
            assert (act_id1 === exp_id1 && act_id2 === exp_id2) else begin
                errors++;
                $display("error %s ids expected %0d/%0d actual %0d/%0d",
                         name, exp_id1, exp_id2, act_id1, act_id2);
            end
        end
        last_issue = act_issue;
        last_id1   = act_id1;
        @(posedge clk);
        m_valid = live;
        if (d1 && act_issue[0]) begin
            m_valid[act_id1] = 1'b1;
            m_rd[act_id1]    = inst1_rd_i;
            m_exu[act_id1]   = inst1_exu_i;
        end
        if (d2 && act_issue[1]) begin
            m_valid[act_id2] = 1'b1;
            m_rd[act_id2]    = inst2_rd_i;
            m_exu[act_id2]   = inst2_exu_i;
        end
        @(negedge clk);
    endtask

    initial begin
        clk     = 0;
        rst_n   = 0;
        seed    = 32'hfc23;
        errors  = 0;
        m_valid = '0;
        clear_inputs();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1;

        run_cycle("reset");                              // empty scoreboard right after reset

        // read of slot k while k completes
        inst1_valid_i = 1;
        inst1_rd_i    = 5;
        inst1_rd_we_i = 1;
        inst1_exu_i   = EXU_MUL;
        run_cycle("raw_commit_setup");
        clear_inputs();
        inst1_valid_i  = 1;
        inst1_rs1_i    = 5;
        commit_valid_i = 1;
        commit_id_i    = last_id1;
        run_cycle("raw_commit");
        assert (last_issue === 2'b11) else begin
            errors++;
            $display("error raw_commit issue_o expected 11 actual %b", last_issue);
        end
        clear_inputs();
        run_cycle("raw_commit_clear");
        assert (busy_o === 1'b0) else begin
            errors++;
            $display("error raw_commit busy_o expected 0 actual %b", busy_o);
        end

        // fill to seven entries without commits
        inst1_valid_i = 1;
        inst1_rd_we_i = 1;
        inst1_exu_i   = EXU_ALU;
        waited = 0;
        while (count_valid() < 7 && waited < 20) begin
            inst1_rd_i = reg_addr_t'(waited % 7 + 1);
            run_cycle("fill");
            waited++;
        end
        if (count_valid() < 7) begin
            $display("scoreboard did not fill to seven entries in time");
            $display("errors: %0d", errors);
            $display("Simulation FAILED");
            $finish;
        end
        repeat (3) begin
            run_cycle("full_hold");
            assert (last_issue === 2'b00) else begin
                errors++;
                $display("error full_hold issue_o expected 00 actual %b", last_issue);
            end
        end
        commit_valid_i = 1;
        commit_id_i    = 0;
        run_cycle("full_commit");                        // count still seven this cycle
        commit_valid_i = 0;
        waited = 0;
        last_issue = 2'b00;
        while (last_issue === 2'b00 && waited < 10) begin
            run_cycle("full_release");
            waited++;
        end
        if (last_issue === 2'b00) begin
            $display("issue did not resume after a slot was freed");
            $display("errors: %0d", errors);
            $display("Simulation FAILED");
            $finish;
        end

        repeat (3000) begin
            drive_random();
            run_cycle("random");
        end

        $display("errors: %0d", errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- tb.f
hdu_pkg.sv
hdu_if.sv
scoreboard.sv
slot_alloc.sv
hazard_check.sv
issue_ctrl.sv
hdu_top.sv
tb_hdu.sv

//--- Bender.yml
package:
  name: hdu

sources:
  - hdu_pkg.sv
  - hdu_if.sv
  - scoreboard.sv
  - slot_alloc.sv
  - hazard_check.sv
  - issue_ctrl.sv
  - hdu_top.sv
  - target: simulation
    files:
      - tb_hdu.sv
